/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - hdl/rv_core_pkg.sv
      - hdl/gpr_file.sv
      - hdl/reg_scoreboard.sv
      - hdl/decode_stage.sv
      - hdl/issue_buffer.sv
      - hdl/alu_stage.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_rv_core.sv

/* hdl/alu_stage.sv */
`timescale 1ns/1ps

module alu_stage (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  rv_core_pkg::word_t    in_pc_i,
    input  rv_core_pkg::inst_t    in_inst_i,
    input  rv_core_pkg::reg_idx_t in_rd_i,
    input  logic                  in_we_i,
    input  rv_core_pkg::alu_op_e  in_op_i,
    input  rv_core_pkg::word_t    in_a_i,
    input  rv_core_pkg::word_t    in_b_i,
    output logic                  retire_valid_o,
    input  logic                  retire_ready_i,
    output rv_core_pkg::word_t    retire_pc_o,
    output rv_core_pkg::inst_t    retire_inst_o,
    output rv_core_pkg::reg_idx_t retire_rd_o,
    output logic                  retire_we_o,
    output rv_core_pkg::word_t    retire_data_o
);
    import rv_core_pkg::*;

    logic [4:0] shamt;
    word_t      result;
    logic       take;

    assign shamt = in_b_i[4:0];

    always_comb begin
        case (in_op_i)
            ALU_ADD:  result = in_a_i + in_b_i;
            ALU_SUB:  result = in_a_i - in_b_i;
            ALU_SLL:  result = in_a_i << shamt;
            ALU_SLT:  result = {31'b0, $signed(in_a_i) < $signed(in_b_i)};
            ALU_SLTU: result = {31'b0, in_a_i < in_b_i};
            ALU_XOR:  result = in_a_i ^ in_b_i;
            ALU_SRL:  result = in_a_i >> shamt;
            ALU_SRA:  result = word_t'($signed(in_a_i) >>> shamt);
            ALU_OR:   result = in_a_i | in_b_i;
            ALU_AND:  result = in_a_i & in_b_i;
            default:  result = in_b_i;
        endcase
    end

    // output slot frees up on the retire edge.
    assign in_ready_o = ~retire_valid_o | retire_ready_i;
    assign take       = in_valid_i & in_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retire_valid_o <= 1'b0;
        end else if (take) begin
            retire_valid_o <= 1'b1;
        end else if (retire_ready_i) begin
            retire_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            retire_pc_o   <= in_pc_i;
            retire_inst_o <= in_inst_i;
            retire_rd_o   <= in_rd_i;
            retire_we_o   <= in_we_i;
            retire_data_o <= result;
        end
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  inst_valid_i,
    output logic                  inst_ready_o,
    input  rv_core_pkg::inst_t    inst_i,
    output rv_core_pkg::reg_idx_t rs1_o,
    output rv_core_pkg::reg_idx_t rs2_o,
    input  rv_core_pkg::word_t    rs1_data_i,
    input  rv_core_pkg::word_t    rs2_data_i,
    input  logic                  hazard_i,
    output logic                  claim_o,
    output logic                  dec_valid_o,
    input  logic                  dec_ready_i,
    output rv_core_pkg::word_t    dec_pc_o,
    output rv_core_pkg::inst_t    dec_inst_o,
    output rv_core_pkg::reg_idx_t dec_rd_o,
    output logic                  dec_we_o,
    output rv_core_pkg::alu_op_e  dec_op_o,
    output rv_core_pkg::word_t    dec_a_o,
    output rv_core_pkg::word_t    dec_b_o
);
    import rv_core_pkg::*;

    word_t      pc_q;
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_u;
    logic       use_rs1;
    logic       use_rs2;
    logic       supported;
    logic       accept;

    // alt selects sub only for register forms, sra for both.
    function automatic alu_op_e funct_op(input logic [2:0] f3, input logic alt,
                                         input logic is_reg);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = (alt && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign rd     = inst_i[11:7];
    assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u  = {inst_i[31:12], 12'b0};

    always_comb begin
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        supported = 1'b1;
        dec_op_o  = ALU_ADD;
        dec_a_o   = rs1_data_i;
        dec_b_o   = rs2_data_i;
        case (opcode)
            OPC_OP: begin
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                dec_op_o = funct_op(funct3, inst_i[30], 1'b1);
            end
            OPC_OP_IMM: begin
                use_rs1  = 1'b1;
                dec_op_o = funct_op(funct3, inst_i[30], 1'b0);
                dec_b_o  = imm_i;
            end
            OPC_LUI: begin
                dec_op_o = ALU_PASS_B;
                dec_a_o  = '0;
                dec_b_o  = imm_u;
            end
            OPC_AUIPC: begin
                dec_a_o = pc_q;
                dec_b_o = imm_u;
            end
            default: supported = 1'b0;
        endcase
    end

    // unread sources go to x0 so they never stall.
    assign rs1_o = use_rs1 ? inst_i[19:15] : '0;
    assign rs2_o = use_rs2 ? inst_i[24:20] : '0;

    assign dec_we_o   = supported && (rd != '0);
    assign dec_rd_o   = rd;
    assign dec_inst_o = inst_i;
    assign dec_pc_o   = pc_q;

    assign inst_ready_o = dec_ready_i & ~hazard_i;
    assign dec_valid_o  = inst_valid_i & ~hazard_i;
    assign accept       = inst_valid_i & inst_ready_o;
    assign claim_o      = accept & dec_we_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (accept) begin
            pc_q <= pc_q + 32'd4;
        end
    end

endmodule

/* hdl/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  rv_core_pkg::reg_idx_t rs1_i,
    input  rv_core_pkg::reg_idx_t rs2_i,
    output rv_core_pkg::word_t    rs1_data_o,
    output rv_core_pkg::word_t    rs2_data_o,
    input  logic                  we_i,
    input  rv_core_pkg::reg_idx_t rd_i,
    input  rv_core_pkg::word_t    rd_data_i
);
    import rv_core_pkg::*;

    word_t regs_q [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs_q[rd_i] <= rd_data_i;
        end
    end

    // x0 reads as zero.
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* hdl/issue_buffer.sv */
`timescale 1ns/1ps

module issue_buffer (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  rv_core_pkg::word_t    in_pc_i,
    input  rv_core_pkg::inst_t    in_inst_i,
    input  rv_core_pkg::reg_idx_t in_rd_i,
    input  logic                  in_we_i,
    input  rv_core_pkg::alu_op_e  in_op_i,
    input  rv_core_pkg::word_t    in_a_i,
    input  rv_core_pkg::word_t    in_b_i,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output rv_core_pkg::word_t    out_pc_o,
    output rv_core_pkg::inst_t    out_inst_o,
    output rv_core_pkg::reg_idx_t out_rd_o,
    output logic                  out_we_o,
    output rv_core_pkg::alu_op_e  out_op_o,
    output rv_core_pkg::word_t    out_a_o,
    output rv_core_pkg::word_t    out_b_o
);
    import rv_core_pkg::*;

    word_t      pc_q   [2];
    inst_t      inst_q [2];
    reg_idx_t   rd_q   [2];
    logic       we_q   [2];
    alu_op_e    op_q   [2];
    word_t      a_q    [2];
    word_t      b_q    [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    assign in_ready_o  = (count_q != 2'd2);
    assign out_valid_o = (count_q != 2'd0);
    assign push        = in_valid_i & in_ready_o;
    assign pop         = out_valid_o & out_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_q[wr_ptr_q]   <= in_pc_i;
            inst_q[wr_ptr_q] <= in_inst_i;
            rd_q[wr_ptr_q]   <= in_rd_i;
            we_q[wr_ptr_q]   <= in_we_i;
            op_q[wr_ptr_q]   <= in_op_i;
            a_q[wr_ptr_q]    <= in_a_i;
            b_q[wr_ptr_q]    <= in_b_i;
        end
    end

    assign out_pc_o   = pc_q[rd_ptr_q];
    assign out_inst_o = inst_q[rd_ptr_q];
    assign out_rd_o   = rd_q[rd_ptr_q];
    assign out_we_o   = we_q[rd_ptr_q];
    assign out_op_o   = op_q[rd_ptr_q];
    assign out_a_o    = a_q[rd_ptr_q];
    assign out_b_o    = b_q[rd_ptr_q];

endmodule

/* hdl/reg_scoreboard.sv */
`timescale 1ns/1ps

module reg_scoreboard (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  rv_core_pkg::reg_idx_t rs1_i,
    input  rv_core_pkg::reg_idx_t rs2_i,
    output logic                  hazard_o,
    input  logic                  claim_i,
    input  rv_core_pkg::reg_idx_t claim_rd_i,
    input  logic                  release_i,
    input  rv_core_pkg::reg_idx_t release_rd_i
);
    import rv_core_pkg::*;

    logic [PENDING_W-1:0] pending_q [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                pending_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_REGS; i++) begin
                // claim and release on the same register cancel.
                if (claim_i && claim_rd_i == reg_idx_t'(i) &&
                    !(release_i && release_rd_i == reg_idx_t'(i))) begin
                    pending_q[i] <= pending_q[i] + 1'b1;
                end else if (release_i && release_rd_i == reg_idx_t'(i) &&
                             !(claim_i && claim_rd_i == reg_idx_t'(i))) begin
                    pending_q[i] <= pending_q[i] - 1'b1;
                end
            end
        end
    end

    assign hazard_o = (pending_q[rs1_i] != '0) || (pending_q[rs2_i] != '0);

endmodule

/* hdl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  inst_valid_i,
    output logic                  inst_ready_o,
    input  rv_core_pkg::inst_t    inst_i,
    output logic                  retire_valid_o,
    input  logic                  retire_ready_i,
    output rv_core_pkg::word_t    retire_pc_o,
    output rv_core_pkg::inst_t    retire_inst_o,
    output rv_core_pkg::reg_idx_t retire_rd_o,
    output logic                  retire_we_o,
    output rv_core_pkg::word_t    retire_data_o
);
    import rv_core_pkg::*;

    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     hazard;
    logic     claim;

    logic     dec_valid;
    logic     dec_ready;
    word_t    dec_pc;
    inst_t    dec_inst;
    reg_idx_t dec_rd;
    logic     dec_we;
    alu_op_e  dec_op;
    word_t    dec_a;
    word_t    dec_b;

    logic     iss_valid;
    logic     iss_ready;
    word_t    iss_pc;
    inst_t    iss_inst;
    reg_idx_t iss_rd;
    logic     iss_we;
    alu_op_e  iss_op;
    word_t    iss_a;
    word_t    iss_b;

    logic     wb_we;

    // the retire handshake is the register write.
    assign wb_we = retire_valid_o & retire_ready_i & retire_we_o;

    decode_stage u_decode_stage (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_i),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .hazard_i     (hazard),
        .claim_o      (claim),
        .dec_valid_o  (dec_valid),
        .dec_ready_i  (dec_ready),
        .dec_pc_o     (dec_pc),
        .dec_inst_o   (dec_inst),
        .dec_rd_o     (dec_rd),
        .dec_we_o     (dec_we),
        .dec_op_o     (dec_op),
        .dec_a_o      (dec_a),
        .dec_b_o      (dec_b)
    );

    reg_scoreboard u_reg_scoreboard (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .hazard_o     (hazard),
        .claim_i      (claim),
        .claim_rd_i   (dec_rd),
        .release_i    (wb_we),
        .release_rd_i (retire_rd_o)
    );

    gpr_file u_gpr_file (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_we),
        .rd_i       (retire_rd_o),
        .rd_data_i  (retire_data_o)
    );

    issue_buffer u_issue_buffer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (dec_valid),
        .in_ready_o  (dec_ready),
        .in_pc_i     (dec_pc),
        .in_inst_i   (dec_inst),
        .in_rd_i     (dec_rd),
        .in_we_i     (dec_we),
        .in_op_i     (dec_op),
        .in_a_i      (dec_a),
        .in_b_i      (dec_b),
        .out_valid_o (iss_valid),
        .out_ready_i (iss_ready),
        .out_pc_o    (iss_pc),
        .out_inst_o  (iss_inst),
        .out_rd_o    (iss_rd),
        .out_we_o    (iss_we),
        .out_op_o    (iss_op),
        .out_a_o     (iss_a),
        .out_b_o     (iss_b)
    );

    alu_stage u_alu_stage (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .in_valid_i     (iss_valid),
        .in_ready_o     (iss_ready),
        .in_pc_i        (iss_pc),
        .in_inst_i      (iss_inst),
        .in_rd_i        (iss_rd),
        .in_we_i        (iss_we),
        .in_op_i        (iss_op),
        .in_a_i         (iss_a),
        .in_b_i         (iss_b),
        .retire_valid_o (retire_valid_o),
        .retire_ready_i (retire_ready_i),
        .retire_pc_o    (retire_pc_o),
        .retire_inst_o  (retire_inst_o),
        .retire_rd_o    (retire_rd_o),
        .retire_we_o    (retire_we_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

/* hdl/rv_core_pkg.sv */
package rv_core_pkg;

    // data and address word.
    typedef logic [31:0] word_t;

    // register index.
    typedef logic [4:0] reg_idx_t;

    // raw instruction word.
    typedef logic [31:0] inst_t;

    // alu operations with pass_b for lui.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // major opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // funct3 encodings shared by op and op-imm.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam word_t RESET_PC = 32'h8000_0000;

    localparam int NUM_REGS = 32;

    // up to three instructions in flight.
    localparam int PENDING_W = 2;

endpackage

/* rv_core.f */
+incdir+verification
hdl/rv_core_pkg.sv
hdl/gpr_file.sv
hdl/reg_scoreboard.sv
hdl/decode_stage.sv
hdl/issue_buffer.sv
hdl/alu_stage.sv
hdl/rv_core.sv
verification/tb_rv_core.sv

/* verification/tb_rv_ref_model.svh */
`ifndef TB_RV_REF_MODEL_SVH
`define TB_RV_REF_MODEL_SVH

// architectural register state of the model.
word_t model_regs [32];

function automatic void clear_model();
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
endfunction

// integer result from funct3 and the alternate bit.
function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
    word_t      r;
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
        3'b000: r = alt ? a - b : a + b;
        3'b001: r = a << sh;
        // signs differ, so the negative one is smaller.
        3'b010: r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
        3'b011: r = {31'b0, a < b};
        3'b100: r = a ^ b;
        3'b101: begin
            r = a >> sh;
            if (alt && a[31]) begin
                r = r | ~(32'hffff_ffff >> sh);
            end
        end
        3'b110: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// expected retire record of one instruction in program order.
function automatic void rv_ref_step(input word_t pc, input inst_t inst,
                                   output reg_idx_t rd, output logic we,
                                   output logic known, output word_t data);
    word_t a;
    word_t b;
    word_t imm_i;
    word_t imm_u;
    a     = model_regs[inst[19:15]];
    b     = model_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_u = {inst[31:12], 12'h000};
    rd    = inst[11:7];
    known = 1'b1;
    data  = '0;
    case (inst[6:0])
        7'b0110011: data = ref_alu(inst[14:12], inst[30], a, b);
        // only srai takes the alternate bit among the immediate forms.
        7'b0010011: data = ref_alu(inst[14:12], inst[30] && inst[14:12] == 3'b101, a, imm_i);
        7'b0110111: data = imm_u;
        7'b0010111: data = pc + imm_u;
        default: known = 1'b0;
    endcase
    we = known && (rd != 5'd0);
    if (we) begin
        model_regs[rd] = data;
    end
endfunction

`endif

/* verification/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int N_RESET   = 1;
    localparam int N_IMM     = 60;
    localparam int N_REG     = 120;
    localparam int N_CHAIN   = 8;
    localparam int CHAIN_LEN = 6;
    localparam int N_BP      = 100;
    localparam int N_UNSUP   = 8;
    localparam int TOTAL_INST = N_RESET + N_IMM + N_REG + N_CHAIN * CHAIN_LEN + N_BP
                                + 2 * N_UNSUP;
    localparam int MAX_CYCLES = 20 * TOTAL_INST + 100;

    logic     clk;
    logic     arst_n_i;
    logic     inst_valid_i;
    logic     inst_ready_o;
    inst_t    inst_i;
    logic     retire_valid_o;
    logic     retire_ready_i;
    word_t    retire_pc_o;
    inst_t    retire_inst_o;
    reg_idx_t retire_rd_o;
    logic     retire_we_o;
    word_t    retire_data_o;

    integer seed;
    integer ready_seed;
    int     errors;
    int     sent;
    int     retired;
    logic   random_ready;
    word_t  next_pc;
    string  test_name;

    word_t    exp_pc_q    [$];
    inst_t    exp_inst_q  [$];
    reg_idx_t exp_rd_q    [$];
    logic     exp_we_q    [$];
    logic     exp_known_q [$];
    word_t    exp_data_q  [$];

    `include "tb_rv_ref_model.svh"

    rv_core dut_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_ready_o   (inst_ready_o),
        .inst_i         (inst_i),
        .retire_valid_o (retire_valid_o),
        .retire_ready_i (retire_ready_i),
        .retire_pc_o    (retire_pc_o),
        .retire_inst_o  (retire_inst_o),
        .retire_rd_o    (retire_rd_o),
        .retire_we_o    (retire_we_o),
        .retire_data_o  (retire_data_o)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s, %s at %0t: expected %h, actual %h",
                     test_name, what, $time, expected, actual);
            errors++;
        end
    endtask

    function automatic inst_t make_r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3,
                                          input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic inst_t make_i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                          input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic inst_t make_u_type(input logic [19:0] imm, input reg_idx_t rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic reg_idx_t rand_reg();
        word_t rnd;
        rnd = $random(seed);
        return rnd[4:0];
    endfunction

    function automatic reg_idx_t rand_dst();
        int unsigned k;
        k = ($unsigned($random(seed)) % 31) + 1;
        return reg_idx_t'(k);
    endfunction

    function automatic inst_t random_reg_op(input reg_idx_t rs1, input reg_idx_t rs2,
                                            input reg_idx_t rd);
        int unsigned k;
        logic [2:0]  f3;
        logic [6:0]  f7;
        k  = $unsigned($random(seed)) % 10;
        f7 = (k == 1 || k == 7) ? 7'h20 : 7'h00;
        case (k)
            0, 1: f3 = F3_ADD;
            2: f3 = F3_SLL;
            3: f3 = F3_SLT;
            4: f3 = F3_SLTU;
            5: f3 = F3_XOR;
            6, 7: f3 = F3_SR;
            8: f3 = F3_OR;
            default: f3 = F3_AND;
        endcase
        return make_r_type(f7, rs2, rs1, f3, rd);
    endfunction

    // lui and auipc only when with_upper is set.
    function automatic inst_t random_imm_op(input reg_idx_t rs1, input reg_idx_t rd,
                                            input logic with_upper);
        word_t       rnd;
        int unsigned k;
        inst_t       inst;
        rnd = $random(seed);
        k   = $unsigned($random(seed)) % (with_upper ? 11 : 9);
        case (k)
            0: inst = make_i_type(rnd[11:0], rs1, F3_ADD, rd);
            1: inst = make_i_type(rnd[11:0], rs1, F3_SLT, rd);
            2: inst = make_i_type(rnd[11:0], rs1, F3_SLTU, rd);
            3: inst = make_i_type(rnd[11:0], rs1, F3_XOR, rd);
            4: inst = make_i_type(rnd[11:0], rs1, F3_OR, rd);
            5: inst = make_i_type(rnd[11:0], rs1, F3_AND, rd);
            6: inst = make_i_type({7'h00, rnd[4:0]}, rs1, F3_SLL, rd);
            7: inst = make_i_type({7'h00, rnd[4:0]}, rs1, F3_SR, rd);
            8: inst = make_i_type({7'h20, rnd[4:0]}, rs1, F3_SR, rd);
            9: inst = make_u_type(rnd[31:12], rd, OPC_LUI);
            default: inst = make_u_type(rnd[31:12], rd, OPC_AUIPC);
        endcase
        return inst;
    endfunction

    // offers one instruction and holds it until it is accepted.
    task automatic send_inst(input inst_t inst);
        reg_idx_t rd;
        logic     we;
        logic     known;
        word_t    data;
        logic     ok;
        rv_ref_step(next_pc, inst, rd, we, known, data);
        exp_pc_q.push_back(next_pc);
        exp_inst_q.push_back(inst);
        exp_rd_q.push_back(rd);
        exp_we_q.push_back(we);
        exp_known_q.push_back(known);
        exp_data_q.push_back(data);
        next_pc = next_pc + 32'd4;
        sent++;
        inst_valid_i = 1'b1;
        inst_i       = inst;
        ok           = 1'b0;
        while (!ok) begin
            @(negedge clk);
            ok = inst_ready_o;
            @(posedge clk);
            #1;
        end
        inst_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_pc_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        #1;
        if (random_ready) begin
            retire_ready_i = ($random(ready_seed) & 1) != 0;
        end else begin
            retire_ready_i = 1'b1;
        end
    end

    // outputs are stable at the falling edge.
    always @(negedge clk) begin : compare
        logic known;
        word_t data;
        if (arst_n_i && retire_valid_o && retire_ready_i) begin
            if (exp_pc_q.size() == 0) begin
                $display("Error at %0t: the core retired pc %h with no instruction outstanding",
                         $time, retire_pc_o);
                errors++;
            end else begin
                check_value("pc", exp_pc_q.pop_front(), retire_pc_o);
                check_value("inst", exp_inst_q.pop_front(), retire_inst_o);
                check_value("rd", {27'b0, exp_rd_q.pop_front()}, {27'b0, retire_rd_o});
                check_value("we", {31'b0, exp_we_q.pop_front()}, {31'b0, retire_we_o});
                known = exp_known_q.pop_front();
                data  = exp_data_q.pop_front();
                if (known) begin
                    check_value("data", data, retire_data_o);
                end
                retired++;
            end
        end
    end

    initial begin : watchdog
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("errors: %0d, instructions sent: %0d, retired: %0d", errors, sent, retired);
        $display("Something failed");
        $finish;
    end

    initial begin : main
        reg_idx_t prev;
        reg_idx_t dst;
        inst_t    bad;
        seed           = 32'ha262;
        ready_seed     = seed + 1;
        clk            = 1'b0;
        arst_n_i       = 1'b0;
        inst_valid_i   = 1'b0;
        inst_i         = '0;
        retire_ready_i = 1'b1;
        random_ready   = 1'b0;
        errors         = 0;
        sent           = 0;
        retired        = 0;
        next_pc        = RESET_PC;
        clear_model();

        test_name = "reset";
        repeat (4) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_value("retire_valid_o while idle", 32'd0, {31'b0, retire_valid_o});
        end
        check_value("inst_ready_o after reset", 32'd1, {31'b0, inst_ready_o});
        @(posedge clk);
        #1;
        send_inst(make_i_type(12'h123, 5'd0, F3_ADD, 5'd1));
        drain();

        test_name = "immediate ops";
        for (int i = 0; i < N_IMM; i++) begin
            send_inst(random_imm_op(rand_reg(), rand_reg(), 1'b1));
        end
        drain();

        test_name = "register ops";
        for (int i = 0; i < N_REG; i++) begin
            send_inst(random_reg_op(rand_reg(), rand_reg(), rand_reg()));
        end
        drain();

        // each link reads the result of the one before it.
        test_name = "dependency chains";
        for (int i = 0; i < N_CHAIN; i++) begin
            prev = rand_dst();
            send_inst(random_imm_op(rand_reg(), prev, 1'b1));
            for (int j = 1; j < CHAIN_LEN; j++) begin
                dst = rand_dst();
                if ($random(seed) & 1) begin
                    send_inst(random_reg_op(prev, ($random(seed) & 1) ? prev : rand_reg(), dst));
                end else begin
                    send_inst(random_imm_op(prev, dst, 1'b0));
                end
                prev = dst;
            end
        end
        drain();

        test_name = "back-pressure";
        random_ready = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            if ($random(seed) & 1) begin
                send_inst(random_reg_op(rand_reg(), rand_reg(), rand_reg()));
            end else begin
                send_inst(random_imm_op(rand_reg(), rand_reg(), 1'b1));
            end
        end
        drain();
        random_ready = 1'b0;
        drain();

        // load and branch encodings each followed by a read of its rd.
        test_name = "unsupported opcodes";
        for (int i = 0; i < N_UNSUP; i++) begin
            dst       = rand_dst();
            bad       = $random(seed);
            bad[11:7] = dst;
            bad[6:0]  = (i % 2 == 0) ? 7'b0000011 : 7'b1100011;
            send_inst(bad);
            send_inst(make_r_type(7'h00, 5'd0, dst, F3_ADD, rand_dst()));
        end
        drain();

        $display("errors: %0d, instructions sent: %0d, retired: %0d", errors, sent, retired);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
